/* rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [3:0]  byte_en_t;

    // ====================
    // Major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // ====================
    // funct3 codes
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;
    localparam funct3_t F3_SB   = 3'b000;
    localparam funct3_t F3_SW   = 3'b010;
    localparam funct3_t F3_ADD  = 3'b000;  // Also SUB with bit 30
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // SRL or SRA by bit 30
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // ALU operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;  // LUI

    localparam word_t INSTR_BYTES = 32'd4;
    localparam word_t NOP_INSTR   = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t RESET_PC    = 32'h0000_0000;

endpackage

/* core_pipe_pkg.sv */
package core_pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded control bundle
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    jalr;
        logic    use_imm;   // Operand b from immediate
        logic    use_pc;    // Operand a from PC
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        funct3_t  funct3;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    result;      // ALU result or memory address
        word_t    store_data;
        reg_idx_t rd;
        funct3_t  funct3;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t rd;
        word_t    data;
    } mem_wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // Writeback, also the forwarding source
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_bus_t;

endpackage

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv_isa_pkg::word_t        instr,
    input  logic                     freeze,
    input  logic                     load_stall,
    input  core_pipe_pkg::redirect_t redirect,
    output rv_isa_pkg::word_t        pc,
    output core_pipe_pkg::if_id_t    if_id
);

    import rv_isa_pkg::*;

    word_t pc_next;

    // Not-taken prediction, execute corrects it
    always_comb begin
        if (freeze)
            pc_next = pc;
        else if (redirect.taken)
            pc_next = redirect.target;
        else if (load_stall)
            pc_next = pc;
        else
            pc_next = pc + INSTR_BYTES;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '{valid: 1'b0, pc: RESET_PC, instr: NOP_INSTR};
        end else if (!freeze) begin
            if (redirect.taken)
                if_id <= '{valid: 1'b0, pc: pc, instr: NOP_INSTR};  // Wrong-path slot
            else if (!load_stall)
                if_id <= '{valid: 1'b1, pc: pc, instr: instr};
        end
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                   clk,
    input  rv_isa_pkg::reg_idx_t   rs1,
    input  rv_isa_pkg::reg_idx_t   rs2,
    input  core_pipe_pkg::wb_bus_t wb,
    output rv_isa_pkg::word_t      rs1_data,
    output rv_isa_pkg::word_t      rs2_data
);

    import rv_isa_pkg::*;

    word_t regs [1:31];  // x0 not stored
    logic  wr_en;

    assign wr_en = wb.we && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en)
            regs[wb.rd] <= wb.data;
    end

    // Same-cycle write shows up on the read side
    assign rs1_data = (rs1 == '0)                ? '0      :
                      (wr_en && (wb.rd == rs1)) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0)                ? '0      :
                      (wr_en && (wb.rd == rs2)) ? wb.data : regs[rs2];

    // A written register reads back one cycle later
    a_read_back: assert property (@(posedge clk) wr_en |=>
        (rs1 != $past(wb.rd)) || (wr_en && (wb.rd == rs1)) || (rs1_data == $past(wb.data)));

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pipe_pkg::if_id_t  if_id,
    input  logic                   freeze,
    input  logic                   flush,
    input  core_pipe_pkg::wb_bus_t wb,
    output core_pipe_pkg::id_ex_t  id_ex,
    output logic                   load_stall
);

    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    opcode_t  opcode;
    funct3_t  funct3;
    reg_idx_t rs1, rs2, rd;
    word_t    rs1_data, rs2_data;
    word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t    imm;
    alu_op_t  op_alu;
    ctrl_t    ctrl;

    // ====================
    // Fields and immediates
    assign opcode = if_id.instr[6:0];
    assign rd     = if_id.instr[11:7];
    assign funct3 = if_id.instr[14:12];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];

    assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
    assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                    if_id.instr[30:25], if_id.instr[11:8], 1'b0};
    assign imm_u = {if_id.instr[31:12], 12'b0};
    assign imm_j = {{11{if_id.instr[31]}}, if_id.instr[31], if_id.instr[19:12],
                    if_id.instr[20], if_id.instr[30:21], 1'b0};

    regfile regfile_inst (
        .clk      (clk),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Bit 30 picks SUB only for register-register ops
    always_comb begin
        case (funct3)
            F3_ADD:  op_alu = (opcode == OPC_OP && if_id.instr[30]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op_alu = ALU_SLL;
            F3_SLT:  op_alu = ALU_SLT;
            F3_SLTU: op_alu = ALU_SLTU;
            F3_XOR:  op_alu = ALU_XOR;
            F3_SR:   op_alu = if_id.instr[30] ? ALU_SRA : ALU_SRL;
            F3_OR:   op_alu = ALU_OR;
            F3_AND:  op_alu = ALU_AND;
        endcase
    end

    // ====================
    // Control generation
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        imm         = imm_i;
        case (opcode)
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                imm            = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.use_pc    = 1'b1;
                imm            = imm_u;
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = op_alu;
            end
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = op_alu;
            end
            OPC_LOAD: begin  // Word loads only
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OPC_STORE: begin
                ctrl.mem_write = (funct3 == F3_SW) || (funct3 == F3_SB);
                ctrl.use_imm   = 1'b1;
                imm            = imm_s;
            end
            OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                imm         = imm_b;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                imm            = imm_j;
            end
            OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jalr      = 1'b1;
            end
            default: ;  // Unknown opcode acts as a NOP
        endcase
    end

    // Load in EX feeding this instruction
    assign load_stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read &&
                        (id_ex.rd != '0) && ((id_ex.rd == rs1) || (id_ex.rd == rs2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!freeze) begin
            if (flush || load_stall)
                id_ex <= '0;  // Bubble
            else
                id_ex <= '{valid: if_id.valid, pc: if_id.pc, rs1_data: rs1_data,
                           rs2_data: rs2_data, imm: imm, rs1: rs1, rs2: rs2, rd: rd,
                           funct3: funct3, ctrl: ctrl};
        end
    end

    // Fetch keeps the stalled instruction in IF/ID
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        load_stall && !freeze && !flush |=> $stable(if_id));

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pipe_pkg::id_ex_t    id_ex,
    input  logic                     freeze,
    input  core_pipe_pkg::wb_bus_t   wb,
    output core_pipe_pkg::ex_mem_t   ex_mem,
    output core_pipe_pkg::redirect_t redirect
);

    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    logic    ex_fwd_ok, wb_fwd_ok;
    word_t   fwd_a, fwd_b;
    word_t   op_a, op_b;
    word_t   alu_out;
    logic    cond;
    ex_mem_t ex_mem_next;

    // ====================
    // Forwarding
    // Loads in EX/MEM are skipped since their data is not back yet
    assign ex_fwd_ok = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
                       (ex_mem.rd != '0);
    assign wb_fwd_ok = wb.we && (wb.rd != '0);

    assign fwd_a = (ex_fwd_ok && (ex_mem.rd == id_ex.rs1)) ? ex_mem.result :
                   (wb_fwd_ok && (wb.rd == id_ex.rs1))     ? wb.data      : id_ex.rs1_data;
    assign fwd_b = (ex_fwd_ok && (ex_mem.rd == id_ex.rs2)) ? ex_mem.result :
                   (wb_fwd_ok && (wb.rd == id_ex.rs2))     ? wb.data      : id_ex.rs2_data;

    assign op_a = id_ex.ctrl.use_pc  ? id_ex.pc  : fwd_a;
    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;

    // ====================
    // ALU
    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // Branch compare on forwarded registers
    always_comb begin
        case (id_ex.funct3)
            F3_BEQ:  cond = (fwd_a == fwd_b);
            F3_BNE:  cond = (fwd_a != fwd_b);
            F3_BLT:  cond = ($signed(fwd_a) <  $signed(fwd_b));
            F3_BGE:  cond = ($signed(fwd_a) >= $signed(fwd_b));
            F3_BLTU: cond = (fwd_a <  fwd_b);
            F3_BGEU: cond = (fwd_a >= fwd_b);
            default: cond = 1'b0;
        endcase
    end

    assign redirect.taken  = id_ex.valid &&
                             (id_ex.ctrl.jump || (id_ex.ctrl.branch && cond));
    assign redirect.target = id_ex.ctrl.jalr ? ((fwd_a + id_ex.imm) & ~word_t'(1))
                                             : (id_ex.pc + id_ex.imm);

    always_comb begin
        ex_mem_next.valid      = id_ex.valid;
        ex_mem_next.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_next.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_next.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_next.result     = id_ex.ctrl.jump ? (id_ex.pc + INSTR_BYTES) : alu_out;
        ex_mem_next.store_data = fwd_b;
        ex_mem_next.rd         = id_ex.rd;
        ex_mem_next.funct3     = id_ex.funct3;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_mem <= '0;
        else if (!freeze)
            ex_mem <= ex_mem_next;
    end

    // Wrong-path slot behind a redirect arrives as a bubble
    a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.taken && !freeze |=> !id_ex.valid);

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pipe_pkg::ex_mem_t ex_mem,
    input  logic                   freeze,
    input  rv_isa_pkg::word_t      dmem_rdata,
    output rv_isa_pkg::word_t      dmem_addr,
    output rv_isa_pkg::word_t      dmem_wdata,
    output rv_isa_pkg::byte_en_t   dmem_be,
    output logic                   dmem_we,
    output core_pipe_pkg::wb_bus_t wb
);

    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    mem_wb_t mem_wb;

    assign dmem_addr = ex_mem.result;
    assign dmem_we   = ex_mem.valid && ex_mem.mem_write && !freeze;

    // Store shaping
    always_comb begin
        if (ex_mem.funct3 == F3_SB) begin
            dmem_wdata = {4{ex_mem.store_data[7:0]}};     // Same byte on every lane
            dmem_be    = byte_en_t'(4'b0001 << ex_mem.result[1:0]);
        end else begin
            dmem_wdata = ex_mem.store_data;
            dmem_be    = 4'b1111;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (!freeze) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.data      <= ex_mem.mem_read ? dmem_rdata : ex_mem.result;
        end
    end

    assign wb.we   = mem_wb.valid && mem_wb.reg_write;
    assign wb.rd   = mem_wb.rd;
    assign wb.data = mem_wb.data;

    // A store waiting on freeze keeps its address and data
    a_frozen_hold: assert property (@(posedge clk) disable iff (!rst_n)
        freeze |=> $stable(ex_mem));

endmodule

/* core.sv */
`timescale 1ns/1ps

module core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::word_t     instr,
    input  logic                  instr_grant,
    output rv_isa_pkg::word_t     imem_addr,
    output rv_isa_pkg::word_t     dmem_addr,
    output rv_isa_pkg::word_t     dmem_wdata,
    output rv_isa_pkg::byte_en_t  dmem_be,
    output logic                  dmem_we,
    input  rv_isa_pkg::word_t     dmem_rdata
);

    import core_pipe_pkg::*;

    logic      freeze;
    logic      load_stall;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    wb_bus_t   wb;

    assign freeze = ~instr_grant;  // No fetch word, whole pipe waits

    fetch_stage fetch_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .freeze     (freeze),
        .load_stall (load_stall),
        .redirect   (redirect),
        .pc         (imem_addr),
        .if_id      (if_id)
    );

    decode_stage decode_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_id      (if_id),
        .freeze     (freeze),
        .flush      (redirect.taken),
        .wb         (wb),
        .id_ex      (id_ex),
        .load_stall (load_stall)
    );

    execute_stage execute_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .freeze   (freeze),
        .wb       (wb),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    memory_stage memory_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .freeze     (freeze),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_we    (dmem_we),
        .wb         (wb)
    );

endmodule

/* tb_core.sv */
`timescale 1ns/1ps

module tb_core;

    import rv_isa_pkg::*;

    localparam int STIM_WORDS   = 256;
    localparam int HDR_WORDS    = 2;   // Program length and store count
    localparam int DMEM_WORDS   = 64;
    localparam int DRAIN_CYCLES = 16;

    logic     clk = 1'b0;
    logic     rst_n;
    word_t    instr;
    logic     instr_grant;
    word_t    imem_addr;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    byte_en_t dmem_be;
    logic     dmem_we;
    word_t    dmem_rdata;

    word_t  stim [0:STIM_WORDS-1];
    word_t  dmem [0:DMEM_WORDS-1];
    int     prog_len;
    int     store_cnt;
    int     exp_base;      // First expected store triple
    int     store_idx;
    int     cycle_cnt;
    int     cycle_limit;
    int     lane;
    int     fill_idx;
    integer seed;

    core core_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_grant (instr_grant),
        .imem_addr   (imem_addr),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_be     (dmem_be),
        .dmem_we     (dmem_we),
        .dmem_rdata  (dmem_rdata)
    );

    always #4 clk = ~clk;  // 8 ns period

    // ====================
    // Compare tasks
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // ====================
    // Memory models
    always_comb begin
        if (imem_addr[31:2] < prog_len)
            instr = stim[HDR_WORDS + imem_addr[31:2]];
        else
            instr = NOP_INSTR;  // Past the program end
    end

    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            for (lane = 0; lane < 4; lane++) begin
                if (dmem_be[lane])
                    dmem[dmem_addr[7:2]][8*lane +: 8] <= dmem_wdata[8*lane +: 8];
            end
        end
    end

    // Grant low about one cycle in five
    always @(posedge clk) begin
        if (!rst_n)
            instr_grant <= 1'b1;
        else
            instr_grant <= ($unsigned($random(seed)) % 5) != 0;
    end

    // ====================
    // Store monitor on the falling clock edge
    always @(negedge clk) begin
        if (!rst_n) begin
            check_bit("dmem_we", dmem_we, 1'b0);
        end else begin
            cycle_cnt++;
            if (cycle_cnt == 1)
                check_word("imem_addr", imem_addr, RESET_PC);
            if (dmem_we && (store_idx >= store_cnt)) begin
                $display("Store to address %h came after all %0d expected stores",
                         dmem_addr, store_cnt);
                $display("** FAIL **");
                $fatal(1, "extra store");
            end else if (dmem_we) begin
                check_word("dmem_addr", dmem_addr, stim[exp_base + 3*store_idx]);
                check_word("dmem_wdata", dmem_wdata, stim[exp_base + 3*store_idx + 1]);
                check_be("dmem_be", dmem_be, byte_en_t'(stim[exp_base + 3*store_idx + 2]));
                store_idx++;
            end
            if ((store_idx < store_cnt) && (cycle_cnt >= cycle_limit)) begin
                $display("timed out before all expected stores appeared");
                $display("** FAIL **");
                $fatal(1, "timeout after %0d cycles", cycle_cnt);
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        instr_grant = 1'b1;
        store_idx   = 0;
        cycle_cnt   = 0;
        seed        = 32'hccc2_08df;
        for (fill_idx = 0; fill_idx < DMEM_WORDS; fill_idx++)
            dmem[fill_idx] = 32'h5a5a_0000 | word_t'(fill_idx);  // Word index in low bits
        $readmemh("core_stim.mem", stim);
        prog_len    = stim[0];
        store_cnt   = stim[1];
        exp_base    = HDR_WORDS + prog_len;
        cycle_limit = prog_len * 8 + 100;
        if ($isunknown(stim[0]) || $isunknown(stim[1]) || (prog_len < 1) ||
            (store_cnt < 1) || (exp_base + 3*store_cnt > STIM_WORDS)) begin
            $display("core_stim.mem is missing or its header does not fit the stimulus array");
            $display("** FAIL **");
            $fatal(1, "bad stimulus file");
        end else begin
            repeat (4) @(posedge clk);
            rst_n <= 1'b1;
            wait (store_idx == store_cnt);
            repeat (DRAIN_CYCLES) @(posedge clk);  // Room for a stray repeated store
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* core_stim.mem */
// Word 0 is the program length and word 1 the expected store count
// Program words follow, then each expected store as address, data and byte enable
00000044 00000018
// Dependent ALU chain
123450b7 67808093 00001117 002081b3
00302023 ff000213 00300293 40418333
001373b3 0053e433 004444b3 00549533
0054d5b3 4054d633 0054a6b3 0054b733
00602223 00702423 00802623 00902823
00a02a23 00b02c23 00c02e23 02d02023
// Load use, then the branch pairs with a poison store on taken paths
02e02223 00002783 00178833 03002423
0a002883 03102623 00528463 0e302e23
00520463 02502823 00521463 0e302e23
00529463 02502a23 00524463 0e302e23
0042c463 02502c23 0042d463 0e302e23
00525463 02502e23 0042e463 0e302e23
00526463 04502023 00527463 0e302e23
// JAL, JALR, byte stores and the final self loop
0042f463 04502223 00c00a6f 0e302e23
0e302e23 05402423 00000a97 011a8b67
0e302e23 0e302e23 05602623 04900823
049008a3 04900923 049009a3 0000006f
// Expected stores
00000000 12346680 0000000f  00000004 12346690 0000000f
00000008 12344610 0000000f  0000000c 12344613 0000000f
00000010 edcbb9e3 0000000f  00000014 6e5dcf18 0000000f
00000018 1db9773c 0000000f  0000001c fdb9773c 0000000f
00000020 00000001 0000000f  00000024 00000000 0000000f
00000028 2468bcf8 0000000f  0000002c 5a5a0028 0000000f
00000030 00000003 0000000f  00000034 00000003 0000000f
00000038 00000003 0000000f  0000003c 00000003 0000000f
00000040 00000003 0000000f  00000044 00000003 0000000f
00000048 000000dc 0000000f  0000004c 000000f0 0000000f
00000050 e3e3e3e3 00000001  00000051 e3e3e3e3 00000002
00000052 e3e3e3e3 00000004  00000053 e3e3e3e3 00000008

/* build.f */
rv_isa_pkg.sv
core_pipe_pkg.sv
fetch_stage.sv
regfile.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core.sv
tb_core.sv
